//--- source/fma_pkg.sv
// fma shared types

package fma_pkg;

   // format widths
   typedef logic [31:0] fp32_t;
   typedef logic [7:0]  exp_t;
   typedef logic [23:0] man_t;
   typedef logic [7:0]  shamt_t;
   typedef logic [49:0] pp_t;
   typedef logic [47:0] prod_t;
   typedef logic [74:0] aligned_t;
   typedef logic [75:0] sum_t;
   typedef logic [6:0]  lz_t;
   typedef logic [26:0] rman_t;  // 24 mantissa bits + g/r/s

   typedef enum logic {
      ALIGN_LEFT  = 1'b0,
      ALIGN_RIGHT = 1'b1   // addend exponent below product exponent
   } align_dir_e;

   typedef enum logic {
      MODE_CONCAT = 1'b0,
      MODE_ADD    = 1'b1
   } add_mode_e;

   localparam int EXP_BIAS           = 127;
   localparam int EXP_MIN_TRUE       = 126;
   localparam int RIGHT_CONCAT_LIMIT = 47;
   localparam int LEFT_CONCAT_LIMIT  = 28;
   localparam int NORM_BASE          = 29;
   localparam int LZ_LIMIT_OFFSET    = 46;
   localparam int BOOTH_GROUPS       = 13;

   typedef struct packed {
      man_t       man_a;
      man_t       man_b;
      man_t       man_c;
      exp_t       prod_exp;
      exp_t       exp_c;
      shamt_t     shift;
      align_dir_e dir;
      logic       sign_ab;
      logic       sign_eff_c;  // addend subtracted
   } s1_s;

   typedef struct packed {
      pp_t        csa_sum;
      pp_t        csa_carry;
      aligned_t   aligned_c;
      add_mode_e  mode;
      align_dir_e dir;
      exp_t       prod_exp;
      exp_t       exp_c;
      logic       sign_ab;
      logic       sign_eff_c;
   } s2_s;

   typedef struct packed {
      sum_t       magnitude;
      logic       sign;
      add_mode_e  mode;
      align_dir_e dir;
      exp_t       prod_exp;
      exp_t       exp_c;
   } s3_s;

   typedef struct packed {
      rman_t             rman;
      logic signed [7:0] exp_adj;
      add_mode_e         mode;
      align_dir_e        dir;
      exp_t              prod_exp;
      exp_t              exp_c;
      logic              sign;
   } s4_s;

endpackage

//--- source/fma_unpack_align.sv
// fma stage 1 unpack and exponent compare
`timescale 1ns/1ps

module fma_unpack_align (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           in_valid,
   input  fma_pkg::fp32_t a,
   input  fma_pkg::fp32_t b,
   input  fma_pkg::fp32_t c,
   output logic           s1_valid,
   output fma_pkg::s1_s   s1
);
   import fma_pkg::*;

   logic signed [7:0] true_a, true_b, true_c, true_ab;
   logic signed [8:0] exp_diff;
   s1_s               s1_d;

   // zero field gets -126, no hidden bit
   function automatic logic signed [7:0] true_exp(input exp_t e);
      return (e == '0) ? 8'(-EXP_MIN_TRUE) : 8'(int'(e) - EXP_BIAS);
   endfunction

   function automatic man_t unpack_man(input fp32_t x);
      return {x[30:23] != '0, x[22:0]};
   endfunction

   assign true_a   = true_exp(a[30:23]);
   assign true_b   = true_exp(b[30:23]);
   assign true_c   = true_exp(c[30:23]);
   assign true_ab  = true_a + true_b;
   assign exp_diff = 9'(true_c) - 9'(true_ab);  // addend minus product

   always_comb begin
      s1_d.man_a      = unpack_man(a);
      s1_d.man_b      = unpack_man(b);
      s1_d.man_c      = unpack_man(c);
      s1_d.prod_exp   = (true_ab == 8'(-EXP_MIN_TRUE)) ? '0 : exp_t'(true_ab + 8'(EXP_BIAS));
      s1_d.exp_c      = c[30:23];
      s1_d.dir        = exp_diff[8] ? ALIGN_RIGHT : ALIGN_LEFT;
      s1_d.shift      = exp_diff[8] ? shamt_t'(-exp_diff) : shamt_t'(exp_diff);
      s1_d.sign_ab    = a[31] ^ b[31];
      s1_d.sign_eff_c = a[31] ^ b[31] ^ c[31];
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         s1 <= s1_d;
      end
   end

endmodule

//--- source/fma_booth_tree.sv
// fma stage 2 booth multiplier tree and addend align
`timescale 1ns/1ps

module fma_booth_tree (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         s1_valid,
   input  fma_pkg::s1_s s1,
   output logic         s2_valid,
   output fma_pkg::s2_s s2
);
   import fma_pkg::*;

   logic [26:0] mb_ext;  // man_b with a zero below for the first window
   pp_t         a_one, a_two;
   pp_t         pp   [BOOTH_GROUPS];
   pp_t         lvl1 [8];
   pp_t         lvl2 [4];
   pp_t         lvl3 [4];
   pp_t         lvl4 [2];
   pp_t         fin  [2];
   pp_t         csa_s, csa_c;
   aligned_t    ext_c;
   s2_s         s2_d;

   function automatic pp_t booth_sel(input logic [2:0] win, input pp_t one, input pp_t two);
      case (win)
         3'b001, 3'b010: return one;
         3'b011:         return two;
         3'b100:         return -two;
         3'b101, 3'b110: return -one;
         default:        return '0;
      endcase
   endfunction

   // 3:2 compressor across the whole vector
   function automatic void fa(input pp_t x, input pp_t y, input pp_t z,
                              output pp_t s, output pp_t cy);
      pp_t maj;
      maj = (x & y) | (y & z) | (z & x);
      s   = x ^ y ^ z;
      cy  = {maj[48:0], 1'b0};
   endfunction

   assign mb_ext = {2'b0, s1.man_b, 1'b0};
   assign a_one  = {26'b0, s1.man_a};
   assign a_two  = {25'b0, s1.man_a, 1'b0};

   for (genvar g = 0; g < BOOTH_GROUPS; g++) begin : g_booth
      assign pp[g] = booth_sel(mb_ext[2*g +: 3], a_one, a_two) << (2 * g);
   end

   always_comb begin
      for (int i = 0; i < 4; i++) begin
         fa(pp[3*i], pp[3*i+1], pp[3*i+2], lvl1[2*i], lvl1[2*i+1]);
      end
      fa(lvl1[0], lvl1[1], lvl1[2], lvl2[0], lvl2[1]);
      fa(lvl1[3], lvl1[4], lvl1[5], lvl2[2], lvl2[3]);
      fa(lvl2[0], lvl2[1], lvl2[2], lvl3[0], lvl3[1]);
      fa(lvl2[3], lvl1[6], lvl1[7], lvl3[2], lvl3[3]);
      fa(lvl3[0], lvl3[1], lvl3[2], lvl4[0], lvl4[1]);
      fa(lvl4[0], lvl4[1], lvl3[3], fin[0], fin[1]);
      fa(fin[0], fin[1], pp[BOOTH_GROUPS-1], csa_s, csa_c);  // last group joins late
   end

   // addend hidden bit lines up with product bit 46
   assign ext_c = {28'b0, s1.man_c, 23'b0};

   always_comb begin
      s2_d.csa_sum    = csa_s;
      s2_d.csa_carry  = csa_c;
      s2_d.dir        = s1.dir;
      s2_d.prod_exp   = s1.prod_exp;
      s2_d.exp_c      = s1.exp_c;
      s2_d.sign_ab    = s1.sign_ab;
      s2_d.sign_eff_c = s1.sign_eff_c;
      if (s1.dir == ALIGN_RIGHT) begin
         s2_d.mode      = (s1.shift > RIGHT_CONCAT_LIMIT) ? MODE_CONCAT : MODE_ADD;
         s2_d.aligned_c = ext_c >> s1.shift;
      end else if (s1.shift > LEFT_CONCAT_LIMIT) begin
         s2_d.mode      = MODE_CONCAT;
         s2_d.aligned_c = {1'b0, s1.man_c, 50'b0};  // parked at the top
      end else begin
         s2_d.mode      = MODE_ADD;
         s2_d.aligned_c = ext_c << s1.shift;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s2_valid <= 1'b0;
      end else begin
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (s1_valid) begin
         s2 <= s2_d;
      end
   end

endmodule

//--- source/fma_add_sign.sv
// fma stage 3 wide add and magnitude
`timescale 1ns/1ps

module fma_add_sign (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         s2_valid,
   input  fma_pkg::s2_s s2,
   output logic         s3_valid,
   output fma_pkg::s3_s s3
);
   import fma_pkg::*;

   prod_t product;
   sum_t  addend;
   sum_t  raw_sum;
   logic  neg;
   s3_s   s3_d;

   assign product = prod_t'(s2.csa_sum + s2.csa_carry);

   // two's complement of the addend when subtracting
   assign addend  = s2.sign_eff_c ? {1'b1, ~s2.aligned_c} : {1'b0, s2.aligned_c};
   assign raw_sum = {28'b0, product} + addend + sum_t'(s2.sign_eff_c);
   assign neg     = raw_sum[75];

   always_comb begin
      s3_d.magnitude = neg ? -raw_sum : raw_sum;
      s3_d.sign      = s2.sign_ab ^ neg;  // flip when the addend won
      s3_d.mode      = s2.mode;
      s3_d.dir       = s2.dir;
      s3_d.prod_exp  = s2.prod_exp;
      s3_d.exp_c     = s2.exp_c;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s3_valid <= 1'b0;
      end else begin
         s3_valid <= s2_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (s2_valid) begin
         s3 <= s3_d;
      end
   end

   a_mag_positive: assert property (@(posedge clk) disable iff (!arst_n)
      s3_valid |-> !s3.magnitude[75])
      else $error("stage 3 magnitude has its top bit set");

endmodule

//--- source/fma_normalize.sv
// fma stage 4 normalize
`timescale 1ns/1ps

module fma_normalize (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         s3_valid,
   input  fma_pkg::s3_s s3,
   output logic         s4_valid,
   output fma_pkg::s4_s s4
);
   import fma_pkg::*;

   lz_t               lz;
   logic signed [8:0] shift_lim;
   logic [7:0]        norm_sh;
   sum_t              shifted;
   s4_s               s4_d;

   // highest set bit wins, all zero gives 75
   function automatic lz_t count_lz(input sum_t v);
      lz_t n;
      n = lz_t'(75);
      for (int i = 0; i < 76; i++) begin
         if (v[i]) begin
            n = lz_t'(75 - i);
         end
      end
      return n;
   endfunction

   assign lz        = count_lz(s3.magnitude);
   assign shift_lim = $signed({2'b0, lz}) - 9'(LZ_LIMIT_OFFSET);

   // small product exponent caps the shift
   assign norm_sh = ($signed({1'b0, s3.prod_exp}) > shift_lim) ? {1'b0, lz} : s3.prod_exp;
   assign shifted = s3.magnitude << norm_sh;

   always_comb begin
      s4_d.rman     = shifted[75:49];
      s4_d.exp_adj  = 8'(NORM_BASE - int'(norm_sh));
      s4_d.mode     = s3.mode;
      s4_d.dir      = s3.dir;
      s4_d.prod_exp = s3.prod_exp;
      s4_d.exp_c    = s3.exp_c;
      s4_d.sign     = s3.sign;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s4_valid <= 1'b0;
      end else begin
         s4_valid <= s3_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (s3_valid) begin
         s4 <= s4_d;
      end
   end

   // only the leading one survives a shift down to bit 0
   a_lz_range: assert property (@(posedge clk) disable iff (!arst_n)
      s3_valid && (s3.magnitude != '0) |-> ((s3.magnitude >> (7'd75 - lz)) == sum_t'(1)))
      else $error("leading zero count does not match the magnitude");

endmodule

//--- source/fma_round_pack.sv
// fma stage 5 round and pack
`timescale 1ns/1ps

module fma_round_pack (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           s4_valid,
   input  fma_pkg::s4_s   s4,
   output logic           out_valid,
   output fma_pkg::fp32_t result
);
   import fma_pkg::*;

   logic guard, rnd, sticky;
   logic round_up;
   logic carry;
   man_t man_rnd;
   exp_t exp_fin;

   // grs only counts in add mode
   assign guard  = (s4.mode == MODE_ADD) & s4.rman[2];
   assign rnd    = (s4.mode == MODE_ADD) & s4.rman[1];
   assign sticky = (s4.mode == MODE_ADD) & s4.rman[0];

   // ties go to even
   assign round_up         = guard & (rnd | sticky | s4.rman[3]);
   assign {carry, man_rnd} = {1'b0, s4.rman[26:3]} + 25'(round_up);

   always_comb begin
      if (s4.mode == MODE_CONCAT && s4.dir == ALIGN_LEFT) begin
         exp_fin = s4.exp_c + exp_t'(carry);  // addend dominates outright
      end else begin
         exp_fin = s4.prod_exp + exp_t'(s4.exp_adj) + exp_t'(carry);
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= s4_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (s4_valid) begin
         result <= {s4.sign, exp_fin, man_rnd[22:0]};
      end
   end

   a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
      !$isunknown(out_valid))
      else $error("out_valid unknown after reset");

endmodule

//--- source/fma_top.sv
// fma five stage pipeline top
`timescale 1ns/1ps

module fma_top (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           in_valid,
   input  fma_pkg::fp32_t a,
   input  fma_pkg::fp32_t b,
   input  fma_pkg::fp32_t c,
   output logic           out_valid,
   output fma_pkg::fp32_t result
);
   import fma_pkg::*;

   logic s1_valid, s2_valid, s3_valid, s4_valid;
   s1_s  s1;
   s2_s  s2;
   s3_s  s3;
   s4_s  s4;

   fma_unpack_align i_unpack_align (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_valid (in_valid),
      .a        (a),
      .b        (b),
      .c        (c),
      .s1_valid (s1_valid),
      .s1       (s1)
   );

   fma_booth_tree i_booth_tree (
      .clk      (clk),
      .arst_n   (arst_n),
      .s1_valid (s1_valid),
      .s1       (s1),
      .s2_valid (s2_valid),
      .s2       (s2)
   );

   fma_add_sign i_add_sign (
      .clk      (clk),
      .arst_n   (arst_n),
      .s2_valid (s2_valid),
      .s2       (s2),
      .s3_valid (s3_valid),
      .s3       (s3)
   );

   fma_normalize i_normalize (
      .clk      (clk),
      .arst_n   (arst_n),
      .s3_valid (s3_valid),
      .s3       (s3),
      .s4_valid (s4_valid),
      .s4       (s4)
   );

   fma_round_pack i_round_pack (
      .clk       (clk),
      .arst_n    (arst_n),
      .s4_valid  (s4_valid),
      .s4        (s4),
      .out_valid (out_valid),
      .result    (result)
   );

endmodule

//--- dv/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

   initial begin
      arst_n = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;  // released away from the sampling edge
   end

endmodule

//--- dv/fma_tb.sv
// fma pipeline testbench
`timescale 1ns/1ps

module fma_tb;
   import fma_pkg::*;

   localparam int NUM_VECS = 15;

   typedef struct packed {
      fp32_t a;
      fp32_t b;
      fp32_t c;
      fp32_t expected;
   } vec_s;

   logic        clk, arst_n;
   logic        in_valid;
   fp32_t       a, b, c;
   logic        out_valid;
   fp32_t       result;
   logic [31:0] vec_mem [0:4*NUM_VECS-1];
   logic [31:0] lfsr;
   int          cycle_cnt;
   int          value_errors;
   int          other_errors;
   fp32_t       exp_q [$];
   int          due_q [$];
   string       name_q [$];

   tb_clock_gen i_clock_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   fma_top i_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .a         (a),
      .b         (b),
      .c         (c),
      .out_valid (out_valid),
      .result    (result)
   );

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bit(output logic bit_out);
      lfsr    = lfsr_step(lfsr);
      bit_out = lfsr[0];
   endtask

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (actual !== expected) begin
         $display("FAILED %s expected %h actual %h", name, expected, actual);
         value_errors++;
      end
   endtask

   function automatic vec_s get_vec(input int idx);
      return {vec_mem[4*idx], vec_mem[4*idx+1], vec_mem[4*idx+2], vec_mem[4*idx+3]};
   endfunction

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // result monitor, sampled mid cycle
   always @(negedge clk) begin
      if (out_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("out_valid pulsed with no operation in flight at cycle %0d", cycle_cnt);
            other_errors++;
         end else begin
            compare(name_q[0], exp_q[0], result);
            compare({name_q[0], "_latency"}, due_q[0], cycle_cnt);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
            void'(name_q.pop_front());
         end
      end else if (out_valid !== 1'b0) begin
         $display("out_valid is unknown at cycle %0d", cycle_cnt);
         other_errors++;
      end
   end

   initial begin
      vec_s        v;
      logic        gap_bit;
      logic [1:0]  gap;
      int          waited;

      in_valid     = 1'b0;
      a            = '0;
      b            = '0;
      c            = '0;
      value_errors = 0;
      other_errors = 0;
      lfsr         = 32'ha8ec20c0;
      $readmemh("dv/fma_testdata.hex", vec_mem);

      waited = 0;
      while (arst_n !== 1'b1 && waited < 20) begin
         @(negedge clk);
         waited++;
      end
      if (arst_n !== 1'b1) begin
         $display("reset was never released");
         other_errors++;
      end

      // pass 0 back to back, pass 1 with random idle gaps
      for (int p = 0; p < 2; p++) begin
         for (int i = 0; i < NUM_VECS; i++) begin
            if (p == 1) begin
               take_bit(gap_bit);
               gap[0] = gap_bit;
               take_bit(gap_bit);
               gap[1] = gap_bit;
               for (int g = 0; g < gap; g++) begin
                  @(negedge clk);
                  in_valid = 1'b0;
               end
            end
            @(negedge clk);
            v        = get_vec(i);
            in_valid = 1'b1;
            a        = v.a;
            b        = v.b;
            c        = v.c;
            exp_q.push_back(v.expected);
            due_q.push_back(cycle_cnt + 5);  // out_valid rises on the fifth edge from here
            name_q.push_back($sformatf("vec%0d_pass%0d", i, p));
         end
      end
      @(negedge clk);
      in_valid = 1'b0;

      waited = 0;
      while (exp_q.size() > 0 && waited < 40) begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() > 0) begin
         $display("timed out with %0d results still missing", exp_q.size());
         other_errors++;
      end
      repeat (8) @(negedge clk);  // catch stray out_valid pulses

      $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- dv/fma_testdata.hex
// columns: a b c expected, single precision hex words
// expected is the fused a*b+c rounded to nearest even
3f800000 3f800000 3f800000 40000000 // one_plus_one
40000000 40400000 3f000000 40d00000 // small_addend_right
40400000 40a00000 40e00000 41b00000 // right_by_one
3fc00000 3fc00000 00000000 40100000 // zero_addend
3f800000 3f800000 21800000 3f800000 // far_right_concat
3f800000 3f800000 41000000 41100000 // left_add
3f800000 3f800000 4e800000 4e800000 // left_concat
c0000000 40400000 3f800000 c0a00000 // negative_product
3f800000 3f800000 c0800000 c0400000 // addend_wins_sign_flip
3f800001 3f800001 bf800002 28800000 // cancel_positive
3f800001 3f800001 bf800004 b47fffff // cancel_negative
3f800000 3f800000 33800000 3f800000 // tie_stays_even
3f800001 3f800000 33800000 3f800002 // tie_rounds_to_even
3f800000 3f800000 33c00000 3f800001 // above_half_up
3fffffff 3f800000 33800000 40000000 // mantissa_carry

//--- vlog.f
source/fma_pkg.sv
source/fma_unpack_align.sv
source/fma_booth_tree.sv
source/fma_add_sign.sv
source/fma_normalize.sv
source/fma_round_pack.sv
source/fma_top.sv
dv/tb_clock_gen.sv
dv/fma_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fma testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module fma_tb -o fma_sim &&
./obj_dir/fma_sim | tee /dev/stderr | grep "TEST PASS" > /dev/null ||
{ echo "simulation failed"; exit 1; }
